/* all.f */
+incdir+test
common/classifier_pkg.sv
design/uart/uart_rx.sv
design/uart/uart_tx.sv
design/transfer/file_transfer.sv
design/score/score_buffer.sv
design/score/score_unit.sv
design/job_control.sv
design/classifier_top.sv
test/tb_classifier.sv

/* common/classifier_pkg.sv */
`default_nettype none

package classifier_pkg;

    // Serial and buffer byte
    typedef logic [7:0] byte_t;

    // 20 buffer entries need 5 address bits
    typedef logic [4:0] buf_addr_t;

    typedef logic [3:0] class_idx_t;     // Class 0 to 9

    typedef logic [15:0] file_index_t;   // Host file number

    localparam int num_classes = 10;
    localparam int buf_depth = 20;       // Scores at 0..9, biases at 10..19

    // Request headers understood by the host
    localparam byte_t hdr_read = 8'd82;   // 'R'
    localparam byte_t hdr_write = 8'd87;  // 'W'

    // Job sequencer state, shown on the LEDs
    typedef enum logic [2:0] {
        idle,
        load,
        score,
        store,
        next
    } job_state_t;

    // Buffer write port, 14 bits
    typedef struct packed {
        logic en;
        buf_addr_t addr;
        byte_t data;
    } buf_wr_t;

    // Transfer request from the sequencer, 18 bits
    typedef struct packed {
        logic start;           // One cycle strobe
        logic write;           // 1 sends to host, 0 reads from host
        file_index_t index;
    } xfer_req_t;

endpackage

`default_nettype wire

/* design/classifier_top.sv */
`default_nettype none

module classifier_top #(
    parameter int clks_per_bit = 5208
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx,
    output classifier_pkg::job_state_t state_led,
    output classifier_pkg::class_idx_t answer,
    output logic number_valid
);

    classifier_pkg::byte_t rx_data, tx_data, buf_rd_data;
    logic rx_rdy, tx_en, tx_busy;
    classifier_pkg::xfer_req_t req;
    logic xfer_done, score_start, score_done;
    classifier_pkg::class_idx_t best;
    classifier_pkg::buf_wr_t ft_wr, su_wr, buf_wr;
    classifier_pkg::buf_addr_t ft_rd_addr, su_rd_addr, buf_rd_addr;

    // Buffer owner follows the sequencer state
    always_comb begin
        case (state_led)
            classifier_pkg::load:  buf_wr = ft_wr;
            classifier_pkg::score: buf_wr = su_wr;
            default:               buf_wr = '0;
        endcase
        buf_rd_addr = (state_led == classifier_pkg::score) ? su_rd_addr : ft_rd_addr;
    end

    uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
        .clk(clk), .reset(reset), .rx(rx), .rx_data(rx_data), .rx_rdy(rx_rdy)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
        .clk(clk), .reset(reset), .tx_data(tx_data), .tx_en(tx_en),
        .tx(tx), .tx_busy(tx_busy)
    );

    file_transfer u_xfer (
        .clk(clk), .reset(reset), .req(req),
        .tx_data(tx_data), .tx_en(tx_en), .tx_busy(tx_busy),
        .rx_data(rx_data), .rx_rdy(rx_rdy),
        .wr(ft_wr), .rd_addr(ft_rd_addr), .rd_data(buf_rd_data), .done(xfer_done)
    );

    score_buffer u_buf (
        .clk(clk), .wr(buf_wr), .rd_addr(buf_rd_addr), .rd_data(buf_rd_data)
    );

    score_unit u_score (
        .clk(clk), .reset(reset), .start(score_start),
        .rd_addr(su_rd_addr), .rd_data(buf_rd_data), .wr(su_wr),
        .done(score_done), .best(best)
    );

    job_control u_ctrl (
        .clk(clk), .reset(reset), .req(req), .xfer_done(xfer_done),
        .score_start(score_start), .score_done(score_done), .best(best),
        .answer(answer), .number_valid(number_valid), .state_led(state_led)
    );

endmodule

`default_nettype wire

/* design/job_control.sv */
`default_nettype none

module job_control (
    input  logic clk,
    input  logic reset,
    output classifier_pkg::xfer_req_t req,
    input  logic xfer_done,
    output logic score_start,
    input  logic score_done,
    input  classifier_pkg::class_idx_t best,
    output classifier_pkg::class_idx_t answer,
    output logic number_valid,
    output classifier_pkg::job_state_t state_led
);

    classifier_pkg::job_state_t state;
    logic [14:0] job_cnt;       // k
    logic start_q;

    assign state_led = state;

    // Read file is 2k, write file is 2k+1
    always_comb begin
        req.start = start_q;
        req.write = (state == classifier_pkg::store);
        req.index = {job_cnt, req.write};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= classifier_pkg::idle;
            job_cnt <= '0;
            start_q <= 1'b0;
            score_start <= 1'b0;
            answer <= '0;
            number_valid <= 1'b0;
        end else begin
            start_q <= 1'b0;
            score_start <= 1'b0;
            number_valid <= 1'b0;
            case (state)
                classifier_pkg::idle: begin
                    state <= classifier_pkg::load;
                    start_q <= 1'b1;
                end
                classifier_pkg::load: begin
                    if (xfer_done) begin
                        state <= classifier_pkg::score;
                        score_start <= 1'b1;
                    end
                end
                classifier_pkg::score: begin
                    if (score_done) begin
                        answer <= best;
                        number_valid <= 1'b1;
                        state <= classifier_pkg::store;
                        start_q <= 1'b1;            // Write back the sums
                    end
                end
                classifier_pkg::store: begin
                    if (xfer_done) state <= classifier_pkg::next;
                end
                classifier_pkg::next: begin
                    job_cnt <= job_cnt + 1'b1;
                    state <= classifier_pkg::load;
                    start_q <= 1'b1;
                end
                default: state <= classifier_pkg::idle;
            endcase
        end
    end

    a_done_in_xfer: assert property (
        @(posedge clk) disable iff (reset)
        xfer_done |-> state inside {classifier_pkg::load, classifier_pkg::store}
    ) else $error("job_control: transfer finished outside load or store");

endmodule

`default_nettype wire

/* design/score/score_buffer.sv */
`default_nettype none

module score_buffer (
    input  logic clk,
    input  classifier_pkg::buf_wr_t wr,
    input  classifier_pkg::buf_addr_t rd_addr,
    output classifier_pkg::byte_t rd_data
);

    classifier_pkg::byte_t mem [classifier_pkg::buf_depth];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];    // Data one cycle after the address
    end

    // Ports come from two masters through the top level select
    a_wr_addr: assert property (
        @(posedge clk) wr.en |-> wr.addr < classifier_pkg::buf_depth
    ) else $error("score_buffer: write address out of range");

    a_rd_addr: assert property (
        @(posedge clk) !$isunknown(rd_addr) |-> rd_addr < classifier_pkg::buf_depth
    ) else $error("score_buffer: read address out of range");

endmodule

`default_nettype wire

/* design/score/score_unit.sv */
`default_nettype none

module score_unit (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output classifier_pkg::buf_addr_t rd_addr,
    input  classifier_pkg::byte_t rd_data,
    output classifier_pkg::buf_wr_t wr,
    output logic done,
    output classifier_pkg::class_idx_t best
);

    logic busy;
    logic phase;                        // 0 reads score, 1 reads bias
    classifier_pkg::class_idx_t idx;
    classifier_pkg::byte_t score_q;
    classifier_pkg::byte_t max_q;       // Running maximum
    classifier_pkg::byte_t sum;
    logic sum_valid;

    // Wraps at 8 bits like the host model
    assign sum = score_q + rd_data;

    // Sum of class idx-1 is ready while score idx is being read
    assign sum_valid = busy && !phase && (idx != '0);

    assign rd_addr = phase ? {1'b0, idx} + 5'(classifier_pkg::num_classes) : {1'b0, idx};

    always_comb begin
        wr.en = sum_valid;
        wr.addr = {1'b0, idx - 1'b1};   // Result goes back over the score
        wr.data = sum;
    end

    // One flush cycle at idx 10 writes the last sum, done follows
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            phase <= 1'b0;
            idx <= '0;
            done <= 1'b0;
            best <= '0;
            max_q <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                phase <= 1'b0;
                idx <= '0;
                max_q <= '0;
                best <= '0;
            end else if (busy) begin
                // Strictly larger keeps the lowest index on ties
                if (sum_valid && sum > max_q) begin
                    max_q <= sum;
                    best <= idx - 1'b1;
                end
                if (phase) begin
                    phase <= 1'b0;
                    idx <= idx + 1'b1;
                end else if (idx == 4'(classifier_pkg::num_classes)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    phase <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && phase) score_q <= rd_data;  // Score word arrives here
    end

endmodule

`default_nettype wire

/* design/transfer/file_transfer.sv */
`default_nettype none

module file_transfer (
    input  logic clk,
    input  logic reset,
    input  classifier_pkg::xfer_req_t req,
    output classifier_pkg::byte_t tx_data,
    output logic tx_en,
    input  logic tx_busy,
    input  classifier_pkg::byte_t rx_data,
    input  logic rx_rdy,
    output classifier_pkg::buf_wr_t wr,
    output classifier_pkg::buf_addr_t rd_addr,
    input  classifier_pkg::byte_t rd_data,
    output logic done
);

    typedef enum logic [2:0] {
        ft_idle,
        ft_head,
        ft_index,
        ft_recv,
        ft_fetch,
        ft_send,
        ft_done
    } ft_state_t;

    ft_state_t state;
    logic write_q;
    classifier_pkg::file_index_t index_q;
    classifier_pkg::buf_addr_t cnt;     // Byte position, also the buffer address

    assign rd_addr = cnt;
    assign done = (state == ft_done);

    // tx_busy rises the cycle after tx_en, so one check per byte is enough
    assign tx_en = !tx_busy && (state == ft_head || state == ft_index || state == ft_send);

    always_comb begin
        case (state)
            ft_head:  tx_data = write_q ? classifier_pkg::hdr_write : classifier_pkg::hdr_read;
            ft_index: tx_data = cnt[0] ? index_q[15:8] : index_q[7:0];   // Low byte first
            default:  tx_data = rd_data;
        endcase
    end

    always_comb begin
        wr.en = (state == ft_recv) && rx_rdy;   // Host bytes elsewhere are dropped
        wr.addr = cnt;
        wr.data = rx_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ft_idle;
            write_q <= 1'b0;
            index_q <= '0;
            cnt <= '0;
        end else begin
            case (state)
                ft_idle: begin
                    if (req.start) begin
                        write_q <= req.write;
                        index_q <= req.index;
                        cnt <= '0;
                        state <= ft_head;
                    end
                end
                ft_head: begin
                    if (tx_en) state <= ft_index;
                end
                ft_index: begin
                    if (tx_en) begin
                        if (cnt[0]) begin
                            cnt <= '0;
                            state <= write_q ? ft_fetch : ft_recv;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                ft_recv: begin
                    if (rx_rdy) begin
                        if (cnt == 5'(classifier_pkg::buf_depth - 1)) begin
                            cnt <= '0;
                            state <= ft_done;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                ft_fetch: state <= ft_send;     // Buffer read latency
                ft_send: begin
                    if (tx_en) begin
                        if (cnt == 5'(classifier_pkg::num_classes - 1)) begin
                            cnt <= '0;
                            state <= ft_done;
                        end else begin
                            cnt <= cnt + 1'b1;
                            state <= ft_fetch;
                        end
                    end
                end
                ft_done: state <= ft_idle;
                default: state <= ft_idle;
            endcase
        end
    end

    a_wr_in_range: assert property (
        @(posedge clk) disable iff (reset) wr.en |-> wr.addr < classifier_pkg::buf_depth
    ) else $error("file_transfer: write address out of range");

    // The sequencer keeps one transfer in flight
    a_req_when_idle: assert property (
        @(posedge clk) disable iff (reset) req.start |-> state == ft_idle
    ) else $error("file_transfer: request while a transfer is running");

endmodule

`default_nettype wire

/* design/uart/uart_rx.sv */
`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = 5208
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output classifier_pkg::byte_t rx_data,
    output logic rx_rdy
);

    localparam int cw = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {st_idle, st_start, st_bits, st_stop} rx_state_t;

    rx_state_t state;
    logic [1:0] rx_sync;            // Two flop synchronizer
    logic [cw-1:0] cnt;
    logic [2:0] bit_idx;
    logic bit_tick;                 // Middle of the current bit
    classifier_pkg::byte_t shift;

    assign bit_tick = (cnt == cw'(clks_per_bit - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_sync <= 2'b11;
            state <= st_idle;
            cnt <= '0;
            bit_idx <= '0;
            rx_rdy <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_rdy <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rx_sync[1]) state <= st_start;   // Falling edge of start bit
                end
                st_start: begin
                    if (cnt == cw'(clks_per_bit / 2 - 1)) begin
                        cnt <= '0;
                        bit_idx <= '0;
                        // A short glitch is not a start bit
                        state <= rx_sync[1] ? st_idle : st_bits;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_bits: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= st_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_tick) begin
                        rx_rdy <= rx_sync[1];   // Bad stop bit drops the frame
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == st_bits && bit_tick) shift <= {rx_sync[1], shift[7:1]};
        if (state == st_stop && bit_tick && rx_sync[1]) rx_data <= shift;
    end

endmodule

`default_nettype wire

/* design/uart/uart_tx.sv */
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 5208
) (
    input  logic clk,
    input  logic reset,
    input  classifier_pkg::byte_t tx_data,
    input  logic tx_en,
    output logic tx,
    output logic tx_busy
);

    localparam int cw = $clog2(clks_per_bit + 1);

    logic [9:0] frame;      // Stop bit, data, start bit in bit 0
    logic [cw-1:0] cnt;
    logic [3:0] bit_cnt;

    // Line idles high since frame fills with ones
    assign tx = frame[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame <= '1;
            cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_en) begin
                frame <= {1'b1, tx_data, 1'b0};
                cnt <= '0;
                bit_cnt <= '0;
                tx_busy <= 1'b1;
            end
        end else if (cnt == cw'(clks_per_bit - 1)) begin
            cnt <= '0;
            frame <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;            // Stop bit done
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // The sender has to wait for the previous frame
    a_no_en_while_busy: assert property (
        @(posedge clk) disable iff (reset) tx_en |-> !tx_busy
    ) else $error("uart_tx: tx_en while a frame is in progress");

endmodule

`default_nettype wire

/* test/tb_host.svh */
`ifndef TB_HOST_SVH
`define TB_HOST_SVH

`default_nettype none

task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
endtask

task automatic abort_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    stop_run();
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_byte(input classifier_pkg::byte_t got,
                          input classifier_pkg::byte_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_index(input classifier_pkg::file_index_t got,
                           input classifier_pkg::file_index_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_answer(input classifier_pkg::class_idx_t got,
                            input classifier_pkg::class_idx_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_state(input classifier_pkg::job_state_t got,
                           input classifier_pkg::job_state_t exp, input string what);
    if (got !== exp) begin
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        stop_run();
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        stop_run();
    end
endtask

// Called on a falling edge, returns in the middle of the stop bit
task automatic recv_frame(output classifier_pkg::byte_t data);
    int waited;
    waited = 0;
    while (tx !== 1'b0) begin
        @(negedge clk);
        waited++;
        if (waited > frame_timeout) abort_timeout("a start bit on tx");
    end
    wait_clocks(clks_per_bit / 2);
    check_bit(tx, 1'b0, "middle of start bit");
    for (int i = 0; i < 8; i++) begin
        wait_clocks(clks_per_bit);
        data[i] = tx;       // LSB first
    end
    wait_clocks(clks_per_bit);
    check_bit(tx, 1'b1, "stop bit on tx");
endtask

task automatic recv_index(output classifier_pkg::file_index_t index);
    classifier_pkg::byte_t lo;
    classifier_pkg::byte_t hi;
    recv_frame(lo);
    recv_frame(hi);
    index = {hi, lo};
endtask

task automatic send_frame(input classifier_pkg::byte_t data);
    rx = 1'b0;
    wait_clocks(clks_per_bit);
    for (int i = 0; i < 8; i++) begin
        rx = data[i];
        wait_clocks(clks_per_bit);
    end
    rx = 1'b1;      // Stop bit, line stays idle after it
    wait_clocks(clks_per_bit);
endtask

task automatic wait_for_answer(input int target);
    int waited;
    waited = 0;
    while (nv_count < target) begin
        @(negedge clk);
        waited++;
        if (waited > answer_timeout) abort_timeout("number_valid after the bias bytes");
    end
endtask

`default_nettype wire

`endif

/* test/tb_classifier.sv */
`default_nettype none

module tb_classifier;

    localparam int clks_per_bit = 8;
    localparam int n_rows = 6;
    localparam int n_fixed = 3;                 // Tie, wraparound and all-equal rows
    localparam int frame_timeout = 40 * clks_per_bit;
    localparam int answer_timeout = 200;
    localparam classifier_pkg::byte_t read_header = 8'd82;    // 'R'
    localparam classifier_pkg::byte_t write_header = 8'd87;   // 'W'

    // Ten bytes per row with class 0 on the left
    typedef classifier_pkg::byte_t [0:classifier_pkg::num_classes-1] row_t;

    logic clk;
    logic reset;
    logic rx;
    logic tx;
    classifier_pkg::job_state_t state_led;
    classifier_pkg::class_idx_t answer;
    logic number_valid;

    // Stimulus and expected values
    row_t scores [n_rows];
    row_t biases [n_rows];
    row_t exp_sums [n_rows];
    classifier_pkg::class_idx_t exp_answer [n_rows];

    int nv_count;           // number_valid cycles seen since reset
    int seed;
    classifier_pkg::byte_t got;
    classifier_pkg::file_index_t idx;

    classifier_top #(.clks_per_bit(clks_per_bit)) UUT (
        .clk(clk), .reset(reset), .rx(rx), .tx(tx),
        .state_led(state_led), .answer(answer), .number_valid(number_valid)
    );

    always #10 clk = ~clk;

    always @(posedge clk or posedge reset) begin
        if (reset) nv_count <= 0;
        else if (number_valid) nv_count <= nv_count + 1;
    end

    function automatic classifier_pkg::byte_t wrapped_sum(input classifier_pkg::byte_t a,
                                                          input classifier_pkg::byte_t b);
        logic [8:0] full;
        full = {1'b0, a} + {1'b0, b};
        return full[7:0];   // Carry out is lost
    endfunction

    // First strictly larger value wins, so ties keep the lower class
    function automatic classifier_pkg::class_idx_t best_class(input row_t sums);
        classifier_pkg::class_idx_t best;
        best = '0;
        for (int i = 1; i < classifier_pkg::num_classes; i++) begin
            if (sums[i] > sums[best]) best = 4'(i);
        end
        return best;
    endfunction

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        rx = 1'b1;
        seed = 76754;
        void'($urandom(seed));

        scores[0] = {8'd5, 8'd20, 8'd3, 8'd40, 8'd7, 8'd9, 8'd40, 8'd1, 8'd0, 8'd2};
        biases[0] = {8'd1, 8'd1, 8'd1, 8'd10, 8'd1, 8'd1, 8'd10, 8'd1, 8'd1, 8'd1};
        // 250 + 10 wraps to 4, so class 1 must not win
        scores[1] = {8'd100, 8'd250, 8'd30, 8'd200, 8'd0, 8'd255, 8'd10, 8'd60, 8'd90, 8'd120};
        biases[1] = {8'd100, 8'd10, 8'd30, 8'd55, 8'd0, 8'd1, 8'd5, 8'd60, 8'd90, 8'd120};
        for (int i = 0; i < classifier_pkg::num_classes; i++) begin
            scores[2][i] = 8'd33;
            biases[2][i] = 8'd7;
        end
        for (int r = n_fixed; r < n_rows; r++) begin
            for (int i = 0; i < classifier_pkg::num_classes; i++) begin
                scores[r][i] = 8'($urandom);
                biases[r][i] = 8'($urandom);
            end
        end
        for (int r = 0; r < n_rows; r++) begin
            for (int i = 0; i < classifier_pkg::num_classes; i++) begin
                exp_sums[r][i] = wrapped_sum(scores[r][i], biases[r][i]);
            end
            exp_answer[r] = best_class(exp_sums[r]);
        end

        repeat (4) @(negedge clk);
        check_bit(tx, 1'b1, "tx in reset");
        check_bit(number_valid, 1'b0, "number_valid in reset");
        check_answer(answer, '0, "answer in reset");
        check_state(state_led, classifier_pkg::idle, "state_led in reset");
        reset = 1'b0;

        for (int k = 0; k < n_rows; k++) begin
            recv_frame(got);
            check_byte(got, read_header, "read header");
            recv_index(idx);
            check_index(idx, 16'(2 * k), "read file index");
            check_state(state_led, classifier_pkg::load, "state_led during load");
            for (int i = 0; i < classifier_pkg::num_classes; i++) send_frame(scores[k][i]);
            for (int i = 0; i < classifier_pkg::num_classes; i++) send_frame(biases[k][i]);

            wait_for_answer(k + 1);
            check_answer(answer, exp_answer[k], $sformatf("answer of row %0d", k));

            recv_frame(got);
            check_byte(got, write_header, "write header");
            recv_index(idx);
            check_index(idx, 16'(2 * k + 1), "write file index");
            check_state(state_led, classifier_pkg::store, "state_led during store");
            for (int i = 0; i < classifier_pkg::num_classes; i++) begin
                recv_frame(got);
                check_byte(got, exp_sums[k][i], $sformatf("row %0d sum of class %0d", k, i));
            end
            check_count(nv_count, k + 1, "number_valid cycles");
        end

        $display("TB PASSED");
        $finish;
    end

`include "tb_host.svh"

endmodule

`default_nettype wire
